// ==== hw/hl_read_buffer.sv ====
// byte memory read at hl, with a preload port and a polarity selectable bus drive.
`default_nettype none

module hl_read_buffer #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  ldrhl_pkg::ctrl_t    ctrl,
    input  logic [15:0]         hl,
    input  logic                mem_we,
    input  logic [ADDR_W-1:0]   mem_addr,
    input  ldrhl_pkg::byte_t    mem_wdata,
    output ldrhl_pkg::byte_t    bus
);
    import ldrhl_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    byte_t             mem [DEPTH];
    byte_t             data_q;
    logic [ADDR_W-1:0] rd_addr;

    // only the low hl bits reach the memory.
    assign rd_addr = hl[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // fetched at the edge ending step 4, held through step 6.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_q <= '0;
        end else if (ctrl.select_hl && ctrl.r0) begin
            data_q <= mem[rd_addr];
        end
    end

    always_comb begin
        if (ctrl.r2) begin
            bus = ctrl.invert_in ? ~data_q : data_q;
        end else begin
            bus = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ld_r_hl_decoder.sv ====
// hardwired decoder for the 01rrr110 group, steps 4 to 6.
`default_nettype none

module ld_r_hl_decoder (
    input  ldrhl_pkg::xpt_t    xpt,
    input  ldrhl_pkg::opcode_t opcode,
    output ldrhl_pkg::ctrl_t   ctrl
);
    import ldrhl_pkg::*;

    logic     group;
    logic     step_en;
    logic     t4;
    logic     t5;
    logic     t6;
    reg_idx_t dst;

    // group match acts as the enable of the whole decoder.
    assign group = (opcode[7:6] == 2'b01) && (opcode[2:0] == 3'b110);

    assign step_en = (xpt == XPT_T4) || (xpt == XPT_T5) || (xpt == XPT_T6);

    assign t4 = (xpt == XPT_T4);
    assign t5 = (xpt == XPT_T5);
    assign t6 = (xpt == XPT_T6);

    assign dst = opcode[5:3];

    always_comb begin
        ctrl = '0;
        if (group) begin
            ctrl.select_hl   = step_en;
            ctrl.r0          = t4;
            ctrl.r1          = t5;
            ctrl.r2          = t6;
            ctrl.reset_xpt   = t6;
            ctrl.set_cm1     = t6;
            ctrl.opcode_hold = t6;
            if (t6) begin
                case (dst)
                    REG_B: ctrl.write_b = 1'b1;
                    REG_C: ctrl.write_c = 1'b1;
                    REG_D: ctrl.write_d = 1'b1;
                    REG_E: ctrl.write_e = 1'b1;
                    REG_H: ctrl.write_h = 1'b1;
                    REG_L: ctrl.write_l = 1'b1;
                    REG_A: ctrl.write_a = 1'b1;
                    // index 6 is (hl), nothing to write.
                    default: ;
                endcase
            end
            // bit 3 clear rows, plus a.
            ctrl.invert_in = t6 && is_inverted(dst);
        end else begin
            // not ours, abort at the first step.
            ctrl.illegal   = t4;
            ctrl.reset_xpt = t4;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ld_r_hl_top.sv ====
// ld r,(hl) execution slice: sequencer, decoder, read buffer and register file.
`default_nettype none

module ld_r_hl_top #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  ldrhl_pkg::opcode_t  start_opcode,
    input  logic                mem_we,
    input  logic [ADDR_W-1:0]   mem_addr,
    input  ldrhl_pkg::byte_t    mem_wdata,
    input  logic                load_we,
    input  ldrhl_pkg::reg_idx_t load_sel,
    input  ldrhl_pkg::byte_t    load_data,
    input  ldrhl_pkg::reg_idx_t rd_sel,
    output logic                busy,
    output logic                done,
    output logic                illegal,
    output ldrhl_pkg::byte_t    rd_data
);
    import ldrhl_pkg::*;

    xpt_t        xpt;
    opcode_t     opcode;
    ctrl_t       ctrl;
    logic [15:0] hl;
    byte_t       bus;

    xpt_sequencer u_seq (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .start_opcode (start_opcode),
        .ctrl         (ctrl),
        .xpt          (xpt),
        .opcode       (opcode),
        .busy         (busy)
    );

    ld_r_hl_decoder u_dec (
        .xpt    (xpt),
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    hl_read_buffer #(
        .ADDR_W (ADDR_W)
    ) u_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .hl        (hl),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .bus       (bus)
    );

    reg_file u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .bus       (bus),
        .load_we   (load_we),
        .load_sel  (load_sel),
        .load_data (load_data),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .hl        (hl)
    );

    // set_cm1 marks the last step of a completed load.
    assign done    = ctrl.set_cm1;
    assign illegal = ctrl.illegal;

endmodule

`default_nettype wire

// ==== hw/ldrhl_pkg.sv ====
// shared types for the ld r,(hl) slice: step, opcode, data and register index,
// the decoder control struct, the sequencer states and the storage polarity rule.
`default_nettype none

package ldrhl_pkg;

    // execution timing step, 0 is idle.
    typedef logic [2:0] xpt_t;

    typedef logic [7:0] opcode_t;

    typedef logic [7:0] byte_t;

    // register index in the cpu encoding, 6 is (hl) and never a register.
    typedef logic [2:0] reg_idx_t;

    localparam xpt_t XPT_IDLE = 3'd0;
    localparam xpt_t XPT_T4   = 3'd4;
    localparam xpt_t XPT_T5   = 3'd5;
    localparam xpt_t XPT_T6   = 3'd6;

    localparam reg_idx_t REG_B    = 3'd0;
    localparam reg_idx_t REG_C    = 3'd1;
    localparam reg_idx_t REG_D    = 3'd2;
    localparam reg_idx_t REG_E    = 3'd3;
    localparam reg_idx_t REG_H    = 3'd4;
    localparam reg_idx_t REG_L    = 3'd5;
    localparam reg_idx_t REG_NONE = 3'd6;
    localparam reg_idx_t REG_A    = 3'd7;

    // decoder strobes, one bit each.
    typedef struct packed {
        logic select_hl;
        logic r0;
        logic r1;
        logic r2;
        logic reset_xpt;
        logic set_cm1;
        logic opcode_hold;
        logic write_b;
        logic write_c;
        logic write_d;
        logic write_e;
        logic write_h;
        logic write_l;
        logic write_a;
        logic invert_in;
        logic illegal;
    } ctrl_t;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } seq_state_e;

    // b, d and h (even index) and a are kept inverted in the register file.
    function automatic logic is_inverted(input reg_idx_t idx);
        return !idx[0] || (idx == REG_A);
    endfunction

endpackage

`default_nettype wire

// ==== hw/reg_file.sv ====
// b, c, d, e, h, l and a with bus write strobes, a load port and a true value read port.
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  ldrhl_pkg::ctrl_t    ctrl,
    input  ldrhl_pkg::byte_t    bus,
    input  logic                load_we,
    input  ldrhl_pkg::reg_idx_t load_sel,
    input  ldrhl_pkg::byte_t    load_data,
    input  ldrhl_pkg::reg_idx_t rd_sel,
    output ldrhl_pkg::byte_t    rd_data,
    output logic [15:0]         hl
);
    import ldrhl_pkg::*;

    // stored form, indexed by the cpu register code; slot 6 stays empty.
    byte_t      store_q [8];
    logic [7:0] strobe;
    byte_t      load_store;
    logic       load_ok;
    byte_t      h_true;
    byte_t      l_true;

    assign strobe = {
        ctrl.write_a,
        1'b0,
        ctrl.write_l,
        ctrl.write_h,
        ctrl.write_e,
        ctrl.write_d,
        ctrl.write_c,
        ctrl.write_b
    };

    // load data arrives true, convert to storage polarity.
    assign load_store = load_data ^ {8{is_inverted(load_sel)}};
    assign load_ok    = load_we && (load_sel != REG_NONE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // true value 0 in every register.
            for (int i = 0; i < 8; i++) begin
                store_q[i] <= {8{is_inverted(reg_idx_t'(i))}};
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (strobe[i]) begin
                    // bus already carries the storage polarity.
                    store_q[i] <= bus;
                end else if (load_ok && (load_sel == reg_idx_t'(i))) begin
                    store_q[i] <= load_store;
                end
            end
        end
    end

    assign rd_data = store_q[rd_sel] ^ {8{is_inverted(rd_sel)}};

    assign h_true = store_q[REG_H] ^ {8{is_inverted(REG_H)}};
    assign l_true = store_q[REG_L] ^ {8{is_inverted(REG_L)}};
    assign hl     = {h_true, l_true};

endmodule

`default_nettype wire

// ==== hw/xpt_sequencer.sv ====
// opcode latch and execution step counter for steps 4 to 6.
`default_nettype none

module xpt_sequencer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  ldrhl_pkg::opcode_t start_opcode,
    input  ldrhl_pkg::ctrl_t   ctrl,
    output ldrhl_pkg::xpt_t    xpt,
    output ldrhl_pkg::opcode_t opcode,
    output logic               busy
);
    import ldrhl_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    xpt_t       xpt_q;
    xpt_t       xpt_d;
    opcode_t    opcode_q;
    logic       accept;

    // a start while running is dropped.
    assign accept = start && (state_q == IDLE);

    always_comb begin
        state_d = state_q;
        xpt_d   = xpt_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = RUN;
                    xpt_d   = XPT_T4;
                end
            end
            RUN: begin
                // step 6 is the last step even without a reset strobe.
                if (ctrl.reset_xpt || (xpt_q == XPT_T6)) begin
                    state_d = IDLE;
                    xpt_d   = XPT_IDLE;
                end else begin
                    xpt_d = xpt_t'(xpt_q + 3'd1);
                end
            end
            default: begin
                state_d = IDLE;
                xpt_d   = XPT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            xpt_q   <= XPT_IDLE;
        end else begin
            state_q <= state_d;
            xpt_q   <= xpt_d;
        end
    end

    // opcode stays held until the decoder lets it go at step 6.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opcode_q <= '0;
        end else if (accept) begin
            opcode_q <= start_opcode;
        end else if (ctrl.opcode_hold) begin
            opcode_q <= '0;
        end
    end

    assign xpt    = xpt_q;
    assign opcode = opcode_q;
    assign busy   = (state_q == RUN);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the ld r,(hl) testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ld_r_hl -f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/Vtb_ld_r_hl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Test OK$"; then
    exit 0
fi
exit 1

// ==== verif/ld_r_hl_sva.sv ====
// timing assertions on done, busy, write strobes and illegal, bound into the top level.
`default_nettype none

module ld_r_hl_sva (
    input logic             clk,
    input logic             arst_n,
    input logic             busy,
    input logic             done,
    input logic             illegal,
    input ldrhl_pkg::ctrl_t ctrl
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [6:0] writes;

    assign writes = {ctrl.write_b, ctrl.write_c, ctrl.write_d, ctrl.write_e,
                     ctrl.write_h, ctrl.write_l, ctrl.write_a};

    // the sequencer is idle right after the last step.
    done_then_idle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !busy)
        else $error("busy still high one cycle after done");

    one_write: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(writes))
        else $error("more than one write strobe active");

    illegal_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        illegal |-> (writes == '0))
        else $error("write strobe active together with illegal");

endmodule

bind ld_r_hl_top ld_r_hl_sva i_sva (
    .clk     (clk),
    .arst_n  (arst_n),
    .busy    (busy),
    .done    (done),
    .illegal (illegal),
    .ctrl    (ctrl)
);

`default_nettype wire

// ==== verif/tb_ld_r_hl.sv ====
// testbench for the ld r,(hl) slice: directed and random loads checked
// against a memory and register model.
`default_nettype none

module tb_ld_r_hl;
    timeunit 1ns;
    timeprecision 1ps;

    import ldrhl_pkg::*;

    localparam int ADDR_W = 8;
    localparam int DEPTH = 1 << ADDR_W;
    localparam int N_DIRECT = 7 + 3 + 4 + 2;
    localparam int N_RANDOM = 200;
    localparam int TIMEOUT_CYCLES = 40 * (N_DIRECT + N_RANDOM) + 100;

    // expected outcome of one instruction.
    typedef struct packed {
        logic            illegal;
        logic [7:0][7:0] regs;
    } expect_t;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              start;
    opcode_t           start_opcode;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    byte_t             mem_wdata;
    logic              load_we;
    reg_idx_t          load_sel;
    byte_t             load_data;
    reg_idx_t          rd_sel;
    logic              busy;
    logic              done;
    logic              illegal;
    byte_t             rd_data;

    byte_t             mem_model [DEPTH];
    logic [7:0][7:0]   reg_model;
    opcode_t           bad_ops [4];
    integer            seed;
    int                cycle_count = 0;

    ld_r_hl_top #(.ADDR_W(ADDR_W)) i_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic byte_t fill_byte(input logic [ADDR_W-1:0] a);
        return (a * 8'd29) ^ {4'h0, a[7:4]} ^ 8'h5c;
    endfunction

    // ld r,(hl) copies the byte at hl into r; anything else is illegal.
    function automatic expect_t expect_load(input opcode_t op, input logic [7:0][7:0] regs);
        expect_t     res;
        logic [15:0] hl_val;
        reg_idx_t    dst;
        res.regs    = regs;
        res.illegal = !((op[7:6] == 2'b01) && (op[2:0] == 3'b110));
        dst         = op[5:3];
        hl_val      = {regs[REG_H], regs[REG_L]};
        if (!res.illegal && (dst != REG_NONE)) begin
            res.regs[dst] = mem_model[hl_val[ADDR_W-1:0]];
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got 0x%02h, expected 0x%02h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic mem_write(input logic [ADDR_W-1:0] addr, input byte_t val);
        @(posedge clk);
        mem_we    <= 1'b1;
        mem_addr  <= addr;
        mem_wdata <= val;
        @(posedge clk);
        mem_we <= 1'b0;
        mem_model[addr] = val;
    endtask

    task automatic load_reg(input reg_idx_t idx, input byte_t val);
        @(posedge clk);
        load_we   <= 1'b1;
        load_sel  <= idx;
        load_data <= val;
        @(posedge clk);
        load_we <= 1'b0;
        if (idx != REG_NONE) begin
            reg_model[idx] = val;
        end
    endtask

    task automatic read_back_all();
        for (int i = 0; i < 8; i++) begin
            if (i != 6) begin
                @(posedge clk);
                rd_sel <= reg_idx_t'(i);
                @(negedge clk);
                check_value($sformatf("rd_data[%0d]", i), rd_data, reg_model[i]);
            end
        end
    endtask

    // one instruction; extra puts a second start strobe into the busy window.
    task automatic run_instr(input opcode_t op, input logic extra, input opcode_t extra_op);
        expect_t exp;
        int      cycles;
        logic    got_done;
        logic    got_illegal;
        exp         = expect_load(op, reg_model);
        cycles      = 0;
        got_done    = 1'b0;
        got_illegal = 1'b0;
        @(posedge clk);
        start        <= 1'b1;
        start_opcode <= op;
        while (!got_done && !got_illegal) begin
            @(posedge clk);
            if (extra && (cycles == 1)) begin
                start        <= 1'b1;
                start_opcode <= extra_op;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            cycles++;
            got_done    = done;
            got_illegal = illegal;
            if (cycles > 8) begin
                $display("no done or illegal within 8 cycles of opcode 0x%02h", op);
                $display("Test FAILED");
                $fatal(1, "no result");
            end
        end
        check_value("illegal", {7'd0, got_illegal}, {7'd0, exp.illegal});
        check_value("done", {7'd0, got_done}, {7'd0, !exp.illegal});
        check_value("cycles to result", 8'(cycles), exp.illegal ? 8'd1 : 8'd3);
        @(negedge clk);
        check_value("busy", {7'd0, busy}, 8'd0);
        reg_model = exp.regs;
        read_back_all();
    endtask

    initial begin
        logic [31:0] r;
        reg_idx_t    idx;
        opcode_t     op;
        logic [15:0] hl_now;
        seed         = 79689;
        arst_n       = 1'b0;
        start        = 1'b0;
        start_opcode = '0;
        mem_we       = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        load_we      = 1'b0;
        load_sel     = '0;
        load_data    = '0;
        rd_sel       = '0;
        reg_model    = '0;
        bad_ops      = '{8'h00, 8'h47, 8'h86, 8'hff};
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        check_value("busy", {7'd0, busy}, 8'd0);
        check_value("done", {7'd0, done}, 8'd0);
        check_value("illegal", {7'd0, illegal}, 8'd0);
        read_back_all();

        for (int a = 0; a < DEPTH; a++) begin
            mem_write(ADDR_W'(a), fill_byte(ADDR_W'(a)));
        end

        // every destination from a fixed hl and byte.
        mem_write(8'h35, 8'hc3);
        for (int d = 0; d < 8; d++) begin
            load_reg(reg_idx_t'(d), 8'(8'h11 * (d + 1)));
        end
        for (int d = 0; d < 8; d++) begin
            if (d != 6) begin
                load_reg(REG_H, 8'h00);
                load_reg(REG_L, 8'h35);
                run_instr({2'b01, reg_idx_t'(d), 3'b110}, 1'b0, 8'h00);
            end
        end

        // l then h rewritten through (hl), next reads follow the new address.
        load_reg(REG_H, 8'h00);
        load_reg(REG_L, 8'h10);
        mem_write(8'h10, 8'h80);
        mem_write(8'h80, 8'h5a);
        run_instr(8'h6e, 1'b0, 8'h00);
        run_instr(8'h7e, 1'b0, 8'h00);
        @(posedge clk);
        rd_sel <= REG_A;
        @(negedge clk);
        check_value("rd_data[7]", rd_data, 8'h5a);
        run_instr(8'h66, 1'b0, 8'h00);

        for (int k = 0; k < 4; k++) begin
            run_instr(bad_ops[k], 1'b0, 8'h00);
        end

        // second start while busy must not touch d or a.
        load_reg(REG_H, 8'h00);
        load_reg(REG_L, 8'h20);
        load_reg(REG_D, ~mem_model[8'h20]);
        load_reg(REG_A, ~mem_model[8'h20]);
        run_instr(8'h4e, 1'b1, 8'h56);
        run_instr(8'h5e, 1'b1, 8'h7e);

        for (int n = 0; n < N_RANDOM; n++) begin
            repeat (2) begin
                r   = $random(seed);
                idx = r[2:0];
                if (idx == REG_NONE) begin
                    idx = REG_A;
                end
                load_reg(idx, r[15:8]);
            end
            r      = $random(seed);
            hl_now = {reg_model[REG_H], reg_model[REG_L]};
            mem_write(hl_now[ADDR_W-1:0], r[7:0]);
            mem_write(r[ADDR_W+7:8], r[23:16]);
            r = $random(seed);
            if (r[2:0] != 3'd0) begin
                op = {2'b01, r[5:3], 3'b110};
            end else begin
                op = r[15:8];
            end
            run_instr(op, 1'b0, 8'h00);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/ldrhl_pkg.sv
hw/xpt_sequencer.sv
hw/ld_r_hl_decoder.sv
hw/hl_read_buffer.sv
hw/reg_file.sv
hw/ld_r_hl_top.sv
verif/ld_r_hl_sva.sv
verif/tb_ld_r_hl.sv
